/* sim.f */
verilog/ooo_cfg_pkg.sv
verilog/ooo_types_pkg.sv
verilog/insn_queue.sv
verilog/dispatch.sv
verilog/register_map.sv
verilog/reorder_buffer.sv
verilog/dispatch_top.sv
tests/tb_clock.sv
tests/dispatch_tb.sv

/* tests/dispatch_tb.sv */
`timescale 1ns/1ps

module dispatch_tb
    import ooo_cfg_pkg::*, ooo_types_pkg::*;
;

    localparam int NUM_INSNS = 68;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0]     addr;
        logic [DATA_WIDTH-1:0]     word;
        alu_op_e                   op;
        logic [REG_ADDR_WIDTH-1:0] rd;     // Zero when nothing is written
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic                      reads1;
        logic                      reads2;
        logic                      use_imm;
        logic [DATA_WIDTH-1:0]     imm;
    } info_t;

    logic       clk;
    logic       i_arst_n;
    logic       i_flush;
    logic       i_insn_wr;
    logic       i_rs_stall;
    logic       o_insn_full;
    insn_t      i_insn;
    cdb_t       i_cdb;
    rs_packet_t o_rs_packet;
    commit_t    o_commit;

    logic [31:0] rng = 32'h6ae9c337;
    logic [31:0] pc = 32'h1000;
    info_t       wr_info;
    info_t       qm[$];                    // Model of the instruction queue
    logic [TAG_WIDTH-1:0] outstanding[$];  // Tags still waiting for a CDB result
    logic [DATA_WIDTH-1:0] arch_val [REGMAP_DEPTH] = '{default: '0};
    logic                  pend [REGMAP_DEPTH] = '{default: 1'b0};
    logic [TAG_WIDTH-1:0]  ptag [REGMAP_DEPTH] = '{default: '0};
    logic                  rob_done [ROB_DEPTH] = '{default: 1'b0};
    logic [DATA_WIDTH-1:0] rob_data [ROB_DEPTH] = '{default: '0};
    logic [REG_ADDR_WIDTH-1:0] rob_rd [ROB_DEPTH] = '{default: '0};
    logic [TAG_WIDTH-1:0] rob_head = '0;
    logic [TAG_WIDTH-1:0] rob_tail = '0;
    int                   rob_cnt = 0;
    logic                 exp_valid = 1'b0;
    rs_packet_t           exp_pkt;

    tb_clock u_clock (.o_clk(clk));

    dispatch_top dut0 (
        .clk(clk), .i_arst_n(i_arst_n), .i_flush(i_flush), .i_insn_wr(i_insn_wr),
        .i_insn(i_insn), .i_rs_stall(i_rs_stall), .i_cdb(i_cdb),
        .o_insn_full(o_insn_full), .o_rs_packet(o_rs_packet), .o_commit(o_commit)
    );

    function automatic logic [31:0] xorshift();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail %s got %h expected %h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    task automatic check_opnd(input string name, input operand_t got, input operand_t exp);
        check_eq({name, ".ready"}, got.ready, exp.ready);
        if (exp.ready) check_eq({name, ".data"}, got.data, exp.data);
        else check_eq({name, ".tag"}, got.tag, exp.tag);
    endtask

    // Map first, then a finished ROB entry, then the live CDB
    function automatic operand_t lookup(input logic [REG_ADDR_WIDTH-1:0] rs);
        operand_t r;
        r = '{ready: 1'b1, tag: '0, data: '0};
        if (rs == '0) return r;
        if (!pend[rs]) r.data = arch_val[rs];
        else if (rob_done[ptag[rs]]) r.data = rob_data[ptag[rs]];
        else if (i_cdb.valid && i_cdb.tag == ptag[rs]) r.data = i_cdb.data;
        else r = '{ready: 1'b0, tag: ptag[rs], data: '0};
        return r;
    endfunction

    function automatic info_t make_insn();
        info_t f;
        logic [31:0] r;
        logic [2:0]  f3;
        int          kind;
        r = xorshift();
        kind = r[31:24] % 13;
        f = '0;
        f.addr = pc;
        f.rd = {2'b00, r[2:0]};  // x0..x7 so that sources often hit pending regs
        f.rs1 = {2'b00, r[5:3]};
        f.rs2 = {2'b00, r[8:6]};
        r = xorshift();
        if (kind < 10) begin
            case (kind)
                0, 1:    f3 = 3'd0;
                2:       f3 = 3'd1;
                3:       f3 = 3'd2;
                4:       f3 = 3'd3;
                5:       f3 = 3'd4;
                6, 7:    f3 = 3'd5;
                8:       f3 = 3'd6;
                default: f3 = 3'd7;
            endcase
            f.word = {(kind == 1 || kind == 7) ? 7'h20 : 7'h00, f.rs2, f.rs1, f3, f.rd, 7'h33};
            f.op = alu_op_e'(kind);
            f.reads1 = 1'b1;
            f.reads2 = 1'b1;
        end else if (kind == 10) begin  // ADDI
            f.word = {r[31:20], f.rs1, 3'b000, f.rd, 7'h13};
            f.op = ALU_ADD;
            f.reads1 = 1'b1;
            f.use_imm = 1'b1;
            f.imm = {{20{r[31]}}, r[31:20]};
        end else if (kind == 11) begin  // LUI
            f.word = {r[31:12], f.rd, 7'h37};
            f.op = ALU_PASS_B;
            f.use_imm = 1'b1;
            f.imm = {r[31:12], 12'h000};
        end else begin                  // LW is not supported
            f.word = {17'h0, 3'b010, f.rd, 7'h03};
            f.op = ALU_NOP;
            f.rd = '0;
        end
        pc = pc + 4;
        return f;
    endfunction

    task automatic model_step();
        logic  accept;
        logic  commit_v;
        logic  fire;
        info_t f;
        accept = i_insn_wr && qm.size() < QUEUE_DEPTH && !i_flush;
        check_eq("o_insn_full", o_insn_full, qm.size() == QUEUE_DEPTH);
        check_eq("o_rs_packet.valid", o_rs_packet.valid, exp_valid);
        if (exp_valid) begin
            check_eq("o_rs_packet.tag", o_rs_packet.tag, exp_pkt.tag);
            check_eq("o_rs_packet.op", o_rs_packet.op, exp_pkt.op);
            check_opnd("o_rs_packet.opnd_a", o_rs_packet.opnd_a, exp_pkt.opnd_a);
            check_opnd("o_rs_packet.opnd_b", o_rs_packet.opnd_b, exp_pkt.opnd_b);
            check_eq("o_rs_packet.iaddr", o_rs_packet.iaddr, exp_pkt.iaddr);
        end
        commit_v = rob_cnt != 0 && rob_done[rob_head] && !i_flush;
        check_eq("o_commit.valid", o_commit.valid, commit_v);
        if (commit_v) begin
            check_eq("o_commit.rdest", o_commit.rdest, rob_rd[rob_head]);
            check_eq("o_commit.data", o_commit.data, rob_data[rob_head]);
        end
        fire = qm.size() != 0 && rob_cnt < ROB_DEPTH && !i_rs_stall && !i_flush;
        exp_valid = fire;
        if (fire) begin
            f = qm.pop_front();
            exp_pkt.tag = rob_tail;
            exp_pkt.op = f.op;
            exp_pkt.opnd_a = lookup(f.reads1 ? f.rs1 : '0);
            exp_pkt.opnd_b = f.use_imm ? '{ready: 1'b1, tag: '0, data: f.imm}
                                       : lookup(f.reads2 ? f.rs2 : '0);
            exp_pkt.iaddr = f.addr;
        end
        if (i_flush) begin
            qm.delete();
            outstanding.delete();
            rob_head = '0;
            rob_tail = '0;
            rob_cnt = 0;
            rob_done = '{default: 1'b0};
            pend = '{default: 1'b0};   // Committed values survive
        end else begin
            if (commit_v) begin
                if (rob_rd[rob_head] != '0) begin
                    arch_val[rob_rd[rob_head]] = rob_data[rob_head];
                    if (ptag[rob_rd[rob_head]] == rob_head) pend[rob_rd[rob_head]] = 1'b0;
                end
                rob_head++;
                rob_cnt--;
            end
            if (fire) begin
                if (f.rd != '0) begin
                    pend[f.rd] = 1'b1;
                    ptag[f.rd] = rob_tail;
                end
                rob_rd[rob_tail] = f.rd;
                rob_done[rob_tail] = 1'b0;
                outstanding.push_back(rob_tail);
                rob_tail++;
                rob_cnt++;
            end
            if (i_cdb.valid) begin
                rob_done[i_cdb.tag] = 1'b1;
                rob_data[i_cdb.tag] = i_cdb.data;
            end
            if (accept) qm.push_back(wr_info);
        end
    endtask

    always @(posedge clk) begin
        if (i_arst_n) model_step();
    end

    // One falling edge of stimulus with CDB results in random order
    task automatic tick(input logic wr, input info_t f, input logic stall, input logic flush);
        logic [31:0] r;
        int          idx;
        @(negedge clk);
        i_flush = flush;
        i_rs_stall = stall;
        i_insn_wr = wr;
        wr_info = f;
        i_insn = '{addr: f.addr, insn: f.word};
        i_cdb = '0;
        r = xorshift();
        if (!flush && outstanding.size() != 0 && r[0]) begin
            idx = r[31:8] % outstanding.size();
            i_cdb = '{valid: 1'b1, tag: outstanding[idx], data: xorshift()};
            outstanding.delete(idx);
        end
    endtask

    task automatic send(input int n);
        info_t f;
        for (int i = 0; i < n; i++) begin
            f = make_insn();
            while (qm.size() == QUEUE_DEPTH) tick(1'b0, f, xorshift() % 8 == 0, 1'b0);
            tick(1'b1, f, xorshift() % 8 == 0, 1'b0);
        end
    endtask

    task automatic drain();
        while (qm.size() != 0 || rob_cnt != 0) tick(1'b0, '0, 1'b0, 1'b0);
        tick(1'b0, '0, 1'b0, 1'b0);
    endtask

    initial begin
        #((NUM_INSNS * 40 + 200) * 8ns);
        $display("Timeout, the run did not finish in time");
        $display("*** FAILED ***");
        $fatal(1);
    end

    initial begin
        i_arst_n = 1'b0;
        i_flush = 1'b0;
        i_insn_wr = 1'b0;
        i_insn = '0;
        i_rs_stall = 1'b0;
        i_cdb = '0;
        wr_info = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        send(40);
        drain();
        for (int i = 0; i < 10; i++) tick(1'b1, make_insn(), 1'b1, 1'b0); // Overfill the queue
        repeat (4) tick(1'b0, '0, 1'b1, 1'b0);
        drain();
        send(6);
        tick(1'b0, '0, 1'b0, 1'b1);
        send(12);
        drain();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    localparam realtime HALF_PERIOD = 4ns;  // 8 ns period

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

endmodule

/* verilog/dispatch.sv */
`timescale 1ns/1ps

module dispatch
    import ooo_cfg_pkg::*, ooo_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_flush,
    input  insn_t                i_head,
    input  logic                 i_empty,
    input  logic                 i_rob_full,
    input  logic                 i_rs_stall,
    input  logic [TAG_WIDTH-1:0] i_rob_tag,
    output logic                 o_pop,
    output rob_alloc_t           o_alloc,
    output lookup_req_t          o_lookup_a,
    output lookup_req_t          o_lookup_b,
    input  operand_t             i_operand_a,
    input  operand_t             i_operand_b,
    output tag_wr_t              o_tag_wr,
    output rs_packet_t           o_rs_packet
);

    logic [DATA_WIDTH-1:0]     word;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic                      fire;
    logic                      has_dest;
    logic                      reads_rs1;
    logic                      reads_rs2;
    logic                      use_imm;
    logic [DATA_WIDTH-1:0]     imm;
    alu_op_e                   op;
    rs_packet_t                pkt_d;
    rs_packet_t                pkt_q;
    logic                      pkt_valid_q;

    // Shared funct3 table of OP and OP-IMM
    function automatic alu_op_e funct_to_op(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign fire = !i_empty && !i_rob_full && !i_rs_stall && !i_flush;
    assign word = i_empty ? NOP_INSN : i_head.insn;
    assign rd   = word[11:7];

    always_comb begin
        op        = ALU_NOP;
        reads_rs1 = 1'b0;
        reads_rs2 = 1'b0;
        use_imm   = 1'b0;
        has_dest  = 1'b0;
        imm       = '0;
        case (opcode_e'(word[6:0]))
            OPC_OP_IMM: begin
                reads_rs1 = 1'b1;
                use_imm   = 1'b1;
                has_dest  = (rd != '0);
                op        = funct_to_op(word[14:12], word[30] && (word[14:12] == 3'b101));
                if (word[13:12] == 2'b01) imm = DATA_WIDTH'(word[24:20]); // Shift amount only
                else imm = {{(DATA_WIDTH-12){word[31]}}, word[31:20]};
            end
            OPC_OP: begin
                reads_rs1 = 1'b1;
                reads_rs2 = 1'b1;
                has_dest  = (rd != '0);
                op        = funct_to_op(word[14:12], word[30]);
            end
            OPC_LUI: begin
                use_imm  = 1'b1;
                has_dest = (rd != '0);
                op       = ALU_PASS_B;
                imm      = {word[31:12], {12{1'b0}}};
            end
            default: ;
        endcase
    end

    // Unread sources look up x0 and come back ready with zero
    assign o_lookup_a.rs = reads_rs1 ? word[19:15] : '0;
    assign o_lookup_b.rs = reads_rs2 ? word[24:20] : '0;

    assign o_pop = fire;

    assign o_alloc.alloc    = fire;
    assign o_alloc.rdest    = rd;
    assign o_alloc.iaddr    = i_head.addr;
    assign o_alloc.has_dest = has_dest;

    assign o_tag_wr.valid = fire && has_dest;
    assign o_tag_wr.rd    = rd;
    assign o_tag_wr.tag   = i_rob_tag;

    always_comb begin
        pkt_d.valid  = fire;
        pkt_d.tag    = i_rob_tag;
        pkt_d.op     = op;
        pkt_d.opnd_a = i_operand_a;
        pkt_d.opnd_b = use_imm ? '{ready: 1'b1, tag: '0, data: imm} : i_operand_b;
        pkt_d.iaddr  = i_head.addr;
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) pkt_valid_q <= 1'b0;
        else pkt_valid_q <= fire;   // One cycle per dispatch
    end

    always_ff @(posedge clk) begin
        if (fire) pkt_q <= pkt_d;
    end

    always_comb begin
        o_rs_packet       = pkt_q;
        o_rs_packet.valid = pkt_valid_q;
    end

endmodule

/* verilog/dispatch_top.sv */
`timescale 1ns/1ps

module dispatch_top
    import ooo_cfg_pkg::*, ooo_types_pkg::*;
(
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_flush,
    input  logic       i_insn_wr,
    input  insn_t      i_insn,
    input  logic       i_rs_stall,
    input  cdb_t       i_cdb,
    output logic       o_insn_full,
    output rs_packet_t o_rs_packet,
    output commit_t    o_commit
);

    insn_t                q_head;
    logic                 q_empty;
    logic                 pop;
    logic                 rob_full;
    logic [TAG_WIDTH-1:0] rob_tag;
    logic [TAG_WIDTH-1:0] commit_tag;
    rob_alloc_t           alloc;
    lookup_req_t          lookup_a;
    lookup_req_t          lookup_b;
    operand_t             map_a;
    operand_t             map_b;
    operand_t             operand_a;
    operand_t             operand_b;
    tag_wr_t              tag_wr;

    insn_queue u_queue (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_flush  (i_flush),
        .i_wr     (i_insn_wr),
        .i_data   (i_insn),
        .i_pop    (pop),
        .o_head   (q_head),
        .o_empty  (q_empty),
        .o_full   (o_insn_full)
    );

    dispatch u_dispatch (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_flush     (i_flush),
        .i_head      (q_head),
        .i_empty     (q_empty),
        .i_rob_full  (rob_full),
        .i_rs_stall  (i_rs_stall),
        .i_rob_tag   (rob_tag),
        .o_pop       (pop),
        .o_alloc     (alloc),
        .o_lookup_a  (lookup_a),
        .o_lookup_b  (lookup_b),
        .i_operand_a (operand_a),
        .i_operand_b (operand_b),
        .o_tag_wr    (tag_wr),
        .o_rs_packet (o_rs_packet)
    );

    register_map u_regmap (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (i_flush),
        .i_tag_wr     (tag_wr),
        .i_commit     (o_commit),
        .i_commit_tag (commit_tag),
        .i_lookup_a   (lookup_a),
        .i_lookup_b   (lookup_b),
        .o_map_a      (map_a),
        .o_map_b      (map_b)
    );

    reorder_buffer u_rob (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_flush      (i_flush),
        .i_alloc      (alloc),
        .o_tag        (rob_tag),
        .o_full       (rob_full),
        .i_cdb        (i_cdb),
        .i_map_a      (map_a),
        .i_map_b      (map_b),
        .o_operand_a  (operand_a),
        .o_operand_b  (operand_b),
        .o_commit     (o_commit),
        .o_commit_tag (commit_tag)
    );

endmodule

/* verilog/insn_queue.sv */
`timescale 1ns/1ps

module insn_queue
    import ooo_cfg_pkg::*, ooo_types_pkg::*;
(
    input  logic  clk,
    input  logic  i_arst_n,
    input  logic  i_flush,
    input  logic  i_wr,
    input  insn_t i_data,
    input  logic  i_pop,
    output insn_t o_head,
    output logic  o_empty,
    output logic  o_full
);

    insn_t                      mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_WIDTH-1:0] rd_ptr_q;
    logic [QUEUE_PTR_WIDTH-1:0] wr_ptr_q;
    logic [QUEUE_PTR_WIDTH:0]   count_q;
    logic                       wr_go;
    logic                       rd_go;

    assign o_empty = (count_q == '0);
    assign o_full  = (count_q == (QUEUE_PTR_WIDTH+1)'(QUEUE_DEPTH));
    assign o_head  = mem[rd_ptr_q];

    assign wr_go = i_wr && !o_full && !i_flush;  // Write when full is dropped
    assign rd_go = i_pop && !o_empty;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (i_flush) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_go) wr_ptr_q <= wr_ptr_q + 1'b1; // Depth is a power of two
            if (rd_go) rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + (QUEUE_PTR_WIDTH+1)'(wr_go) - (QUEUE_PTR_WIDTH+1)'(rd_go);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

endmodule

/* verilog/ooo_cfg_pkg.sv */
package ooo_cfg_pkg;

    localparam int DATA_WIDTH     = 32;
    localparam int ADDR_WIDTH     = 32;
    localparam int REG_ADDR_WIDTH = 5;

    localparam int REGMAP_DEPTH = 32;
    localparam int ROB_DEPTH    = 16;
    localparam int TAG_WIDTH    = 4;    // log2 of ROB_DEPTH

    localparam int QUEUE_DEPTH     = 8;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);

    localparam logic [DATA_WIDTH-1:0] NOP_INSN = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

/* verilog/ooo_types_pkg.sv */
package ooo_types_pkg;

    import ooo_cfg_pkg::*;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B, // LUI
        ALU_NOP
    } alu_op_e;

    // Major opcodes handled by dispatch
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] insn;
    } insn_t;

    typedef struct packed {
        logic                  ready;
        logic [TAG_WIDTH-1:0]  tag;    // Producer entry while not ready
        logic [DATA_WIDTH-1:0] data;
    } operand_t;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        alu_op_e               op;
        operand_t              opnd_a;
        operand_t              opnd_b;
        logic [ADDR_WIDTH-1:0] iaddr;
    } rs_packet_t;

    typedef struct packed {
        logic                      alloc;
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [ADDR_WIDTH-1:0]     iaddr;
        logic                      has_dest;
    } rob_alloc_t;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } cdb_t;

    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] rs;
    } lookup_req_t;

    typedef operand_t lookup_rsp_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [TAG_WIDTH-1:0]      tag;
    } tag_wr_t;

    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [DATA_WIDTH-1:0]     data;
    } commit_t;

    // ROB payload, the done bits live beside it
    typedef struct packed {
        logic                      has_dest;
        logic [REG_ADDR_WIDTH-1:0] rdest;
        logic [DATA_WIDTH-1:0]     data;
    } rob_entry_t;

endpackage

/* verilog/register_map.sv */
`timescale 1ns/1ps

module register_map
    import ooo_cfg_pkg::*, ooo_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_flush,
    input  tag_wr_t              i_tag_wr,
    input  commit_t              i_commit,
    input  logic [TAG_WIDTH-1:0] i_commit_tag,
    input  lookup_req_t          i_lookup_a,
    input  lookup_req_t          i_lookup_b,
    output operand_t             o_map_a,
    output operand_t             o_map_b
);

    operand_t regs_q [REGMAP_DEPTH];
    logic     commit_hit;

    assign commit_hit = i_commit.valid && (i_commit.rdest != '0);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < REGMAP_DEPTH; i++) begin
                regs_q[i] <= '{ready: 1'b1, tag: '0, data: '0};
            end
        end else if (i_flush) begin
            for (int i = 0; i < REGMAP_DEPTH; i++) begin
                regs_q[i].ready <= 1'b1;    // Values stay as committed
            end
        end else begin
            if (commit_hit) begin
                regs_q[i_commit.rdest].data <= i_commit.data;
                // A younger writer may own the register by now
                if (regs_q[i_commit.rdest].tag == i_commit_tag) begin
                    regs_q[i_commit.rdest].ready <= 1'b1;
                end
            end
            if (i_tag_wr.valid && i_tag_wr.rd != '0) begin // Wins over commit
                regs_q[i_tag_wr.rd].ready <= 1'b0;
                regs_q[i_tag_wr.rd].tag   <= i_tag_wr.tag;
            end
        end
    end

    function automatic operand_t read_reg(input logic [REG_ADDR_WIDTH-1:0] idx);
        if (idx == '0) return '{ready: 1'b1, tag: '0, data: '0};
        return regs_q[idx];
    endfunction

    always_comb begin
        o_map_a = read_reg(i_lookup_a.rs);
        o_map_b = read_reg(i_lookup_b.rs);
    end

endmodule

/* verilog/reorder_buffer.sv */
`timescale 1ns/1ps

module reorder_buffer
    import ooo_cfg_pkg::*, ooo_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_arst_n,
    input  logic                 i_flush,
    input  rob_alloc_t           i_alloc,
    output logic [TAG_WIDTH-1:0] o_tag,
    output logic                 o_full,
    input  cdb_t                 i_cdb,
    input  operand_t             i_map_a,
    input  operand_t             i_map_b,
    output operand_t             o_operand_a,
    output operand_t             o_operand_b,
    output commit_t              o_commit,
    output logic [TAG_WIDTH-1:0] o_commit_tag
);

    rob_entry_t           entries_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    logic [TAG_WIDTH-1:0] head_q;
    logic [TAG_WIDTH-1:0] tail_q;
    logic [TAG_WIDTH:0]   count_q;
    logic                 alloc_go;
    logic                 commit_go;

    assign o_full       = (count_q == (TAG_WIDTH+1)'(ROB_DEPTH));
    assign o_tag        = tail_q;                     // Next tag handed to dispatch
    assign o_commit_tag = head_q;

    assign alloc_go  = i_alloc.alloc && !o_full;
    assign commit_go = (count_q != '0) && done_q[head_q] && !i_flush;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else if (i_flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_go) begin
                tail_q         <= tail_q + 1'b1; // Wraps at ROB_DEPTH
                done_q[tail_q] <= 1'b0;
            end
            if (i_cdb.valid) done_q[i_cdb.tag] <= 1'b1;
            if (commit_go) head_q <= head_q + 1'b1;
            count_q <= count_q + (TAG_WIDTH+1)'(alloc_go) - (TAG_WIDTH+1)'(commit_go);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_go) begin
            entries_q[tail_q].has_dest <= i_alloc.has_dest;
            entries_q[tail_q].rdest    <= i_alloc.rdest;
        end
        if (i_cdb.valid) begin
            entries_q[i_cdb.tag].data <= i_cdb.data;
        end
    end

    // Pending map operand, try the finished entry first and then the live CDB
    function automatic lookup_rsp_t resolve(input operand_t m);
        lookup_rsp_t r;
        r = m;
        if (!m.ready) begin
            if (done_q[m.tag]) begin
                r.ready = 1'b1;
                r.data  = entries_q[m.tag].data;
            end else if (i_cdb.valid && i_cdb.tag == m.tag) begin
                r.ready = 1'b1;
                r.data  = i_cdb.data;
            end
        end
        return r;
    endfunction

    always_comb begin
        o_operand_a = resolve(i_map_a);
        o_operand_b = resolve(i_map_b);
    end

    always_comb begin
        o_commit.valid = commit_go;
        o_commit.rdest = entries_q[head_q].has_dest ? entries_q[head_q].rdest : '0;
        o_commit.data  = entries_q[head_q].data;
    end

endmodule
